// File: rtl/exu_pkg.sv
// Execute stage shared types
// Word types, RV32I opcodes, decode groups and the decode-info union
package exu_pkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  reg_addr_t;  // Register file index

    localparam int    DEC_INFO_W  = 14;     // Union payload width
    localparam word_t LINK_OFFSET = 32'd4;  // Link value and fall-through step

    // RV32I major opcodes handled by this stage
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        GRP_ILL = 2'd0,  // No unit owns it
        GRP_ALU = 2'd1,  // Register result only
        GRP_BJP = 2'd2   // Branch or jump
    } dec_grp_e;

    // One-hot ALU operation
    typedef struct packed {
        logic op_lui;
        logic op_auipc;
        logic op_add;
        logic op_sub;
        logic op_sll;
        logic op_slt;
        logic op_sltu;
        logic op_xor;
        logic op_srl;
        logic op_sra;
        logic op_or;
        logic op_and;
    } alu_op_t;

    // ALU view, fills the whole payload so no padding bits remain
    typedef struct packed {
        alu_op_t alu_op;
        logic    op1_pc;   // Operand 1 is the PC
        logic    op2_imm;  // Operand 2 is the immediate
    } alu_info_t;

    // One-hot branch condition
    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bltu;
        logic bge;
        logic bgeu;
    } bjp_br_t;

    typedef struct packed {
        logic [DEC_INFO_W-9:0] pad;   // Unused, kept zero
        logic                  jump;  // JAL or JALR
        logic                  jalr;  // Target based on rs1
        bjp_br_t               br;
    } bjp_info_t;

    // Same bits, meaning picked by the group beside it
    typedef union packed {
        alu_info_t alu;
        bjp_info_t bjp;
    } dec_info_u;

    typedef struct packed {
        dec_grp_e  grp;
        dec_info_u info;
    } dec_info_t;

endpackage

// File: rtl/exu_req_if.sv
// Dispatch request channel
// Carries one request with its two operands and decode info to a unit
`timescale 1ns/1ps

interface exu_req_if import exu_pkg::*; ();

    logic      req;   // Unit owns this instruction
    word_t     op1;   // First operand
    word_t     op2;   // Second operand
    dec_info_u info;  // Decode word, zero when not requested

    // Driven by the dispatcher
    modport dispatch (
        output req,
        output op1,
        output op2,
        output info
    );

    // Seen by an execution unit
    modport unit (
        input req,
        input op1,
        input op2,
        input info
    );

endinterface

// File: rtl/inst_decode.sv
// RV32I instruction decoder
// Sorts the opcode into a group, builds the group's view of the decode word,
// and forms rd and the immediate
`timescale 1ns/1ps

module inst_decode import exu_pkg::*; (
    input  word_t     inst_i,
    output dec_info_t dec_info_o,
    output word_t     dec_imm_o,
    output reg_addr_t rd_addr_o,
    output logic      rd_we_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_bit;  // inst[30], sub and sra select
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign alt_bit = inst_i[30];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // funct3 decode shared by OP and OP-IMM
    function automatic alu_op_t alu_op_dec(input logic [2:0] f3, input logic alt,
                                           input logic is_imm);
        alu_op_t op;
        op = '0;
        case (f3)
            3'b000: begin
                if (alt && !is_imm) op.op_sub = 1'b1;  // No subi in RV32I
                else op.op_add = 1'b1;
            end
            3'b001: op.op_sll  = 1'b1;
            3'b010: op.op_slt  = 1'b1;
            3'b011: op.op_sltu = 1'b1;
            3'b100: op.op_xor  = 1'b1;
            3'b101: begin
                if (alt) op.op_sra = 1'b1;
                else op.op_srl = 1'b1;
            end
            3'b110: op.op_or   = 1'b1;
            default: op.op_and = 1'b1;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_info_o = '0;  // Illegal unless matched below
        dec_imm_o  = '0;
        case (opcode)
            OPC_OP: begin
                dec_info_o.grp             = GRP_ALU;
                dec_info_o.info.alu.alu_op = alu_op_dec(funct3, alt_bit, 1'b0);
            end
            OPC_OP_IMM: begin
                dec_info_o.grp              = GRP_ALU;
                dec_info_o.info.alu.alu_op  = alu_op_dec(funct3, alt_bit, 1'b1);
                dec_info_o.info.alu.op2_imm = 1'b1;
                dec_imm_o                   = imm_i;  // Low 5 bits are shamt
            end
            OPC_LUI: begin
                dec_info_o.grp                    = GRP_ALU;
                dec_info_o.info.alu.alu_op.op_lui = 1'b1;  // 0 + imm
                dec_info_o.info.alu.op2_imm       = 1'b1;
                dec_imm_o                         = imm_u;
            end
            OPC_AUIPC: begin
                dec_info_o.grp                      = GRP_ALU;
                dec_info_o.info.alu.alu_op.op_auipc = 1'b1;  // pc + imm
                dec_info_o.info.alu.op1_pc          = 1'b1;
                dec_info_o.info.alu.op2_imm         = 1'b1;
                dec_imm_o                           = imm_u;
            end
            OPC_BRANCH: begin
                dec_info_o.grp = GRP_BJP;
                dec_imm_o      = imm_b;
                case (funct3)
                    3'b000: dec_info_o.info.bjp.br.beq  = 1'b1;
                    3'b001: dec_info_o.info.bjp.br.bne  = 1'b1;
                    3'b100: dec_info_o.info.bjp.br.blt  = 1'b1;
                    3'b101: dec_info_o.info.bjp.br.bge  = 1'b1;
                    3'b110: dec_info_o.info.bjp.br.bltu = 1'b1;
                    3'b111: dec_info_o.info.bjp.br.bgeu = 1'b1;
                    default: dec_info_o.grp = GRP_ILL;  // 010, 011 reserved
                endcase
            end
            OPC_JAL: begin
                dec_info_o.grp           = GRP_BJP;
                dec_info_o.info.bjp.jump = 1'b1;
                dec_imm_o                = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    dec_info_o.grp           = GRP_BJP;
                    dec_info_o.info.bjp.jump = 1'b1;
                    dec_info_o.info.bjp.jalr = 1'b1;
                    dec_imm_o                = imm_i;
                end
            end
            default: ;  // Load, store, fence, system and unknown stay illegal
        endcase
    end

    assign rd_addr_o = inst_i[11:7];
    // Writes for ALU ops and jump links, never branches
    assign rd_we_o   = (dec_info_o.grp == GRP_ALU) |
                       ((dec_info_o.grp == GRP_BJP) & dec_info_o.info.bjp.jump);

endmodule

// File: rtl/exu_dispatch.sv
// Execute dispatcher
// Selects operands and raises the request of the unit owning the instruction;
// jumps also go to the ALU for the link value
`timescale 1ns/1ps

module exu_dispatch import exu_pkg::*; (
    input  dec_info_t          dec_info_i,
    input  word_t              dec_imm_i,
    input  word_t              dec_pc_i,
    input  word_t              rs1_rdata_i,
    input  word_t              rs2_rdata_i,
    exu_req_if.dispatch        alu_req,
    exu_req_if.dispatch        bjp_req
);

    logic      op_alu;
    logic      op_bjp;
    logic      op_jump;
    alu_info_t alu_info;   // Zero unless ALU group
    bjp_info_t bjp_info;   // Zero unless BJP group
    alu_info_t alu_view;   // What the ALU actually sees
    word_t     alu_op1;
    word_t     alu_op2;

    assign op_alu = (dec_info_i.grp == GRP_ALU);
    assign op_bjp = (dec_info_i.grp == GRP_BJP);

    assign alu_info = op_alu ? dec_info_i.info.alu : '0;
    assign bjp_info = op_bjp ? dec_info_i.info.bjp : '0;
    assign op_jump  = bjp_info.jump;

    // Jump link is computed as a plain add
    always_comb begin
        alu_view = alu_info;
        if (op_jump) begin
            alu_view               = '0;
            alu_view.alu_op.op_add = 1'b1;
        end
    end

    // PC for auipc and links, zero for lui
    assign alu_op1 = (alu_info.op1_pc | op_jump) ? dec_pc_i :
                     alu_info.alu_op.op_lui      ? '0       : rs1_rdata_i;
    assign alu_op2 = alu_info.op2_imm ? dec_imm_i : rs2_rdata_i;

    assign alu_req.req  = op_alu | op_jump;
    assign alu_req.op1  = (op_alu | op_jump) ? alu_op1 : '0;
    assign alu_req.op2  = op_jump ? LINK_OFFSET : op_alu ? alu_op2 : '0;
    assign alu_req.info = dec_info_u'(alu_view);

    // Compare operands for branches
    assign bjp_req.req  = op_bjp;
    assign bjp_req.op1  = op_bjp ? rs1_rdata_i : '0;
    assign bjp_req.op2  = op_bjp ? rs2_rdata_i : '0;
    assign bjp_req.info = dec_info_u'(bjp_info);

endmodule

// File: rtl/exu_alu.sv
// Integer ALU
// OP, OP-IMM, LUI, AUIPC and jump link values from a one-hot op field
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
    exu_req_if.unit req,
    output word_t   result_o
);

    alu_op_t    op;
    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    word_t      res;

    assign op    = req.info.alu.alu_op;
    assign op1   = req.op1;
    assign op2   = req.op2;
    assign shamt = op2[4:0];  // Only low 5 bits shift

    assign sum  = op1 + op2;  // add, lui, auipc and links
    assign diff = op1 - op2;

    // One-hot select as an AND-OR mux
    assign res = ({32{op.op_add | op.op_lui | op.op_auipc}} & sum)
               | ({32{op.op_sub}}  & diff)
               | ({32{op.op_sll}}  & (op1 << shamt))
               | ({32{op.op_slt}}  & {31'b0, $signed(op1) < $signed(op2)})
               | ({32{op.op_sltu}} & {31'b0, op1 < op2})
               | ({32{op.op_xor}}  & (op1 ^ op2))
               | ({32{op.op_srl}}  & (op1 >> shamt))
               | ({32{op.op_sra}}  & word_t'($signed(op1) >>> shamt))
               | ({32{op.op_or}}   & (op1 | op2))
               | ({32{op.op_and}}  & (op1 & op2));

    assign result_o = req.req ? res : '0;  // Quiet when not requested

endmodule

// File: rtl/exu_bjp.sv
// Branch and jump unit
// Evaluates the six branch conditions and forms the redirect target
`timescale 1ns/1ps

module exu_bjp import exu_pkg::*; (
    exu_req_if.unit req,
    input  word_t   pc_i,
    input  word_t   rs1_rdata_i,
    input  word_t   imm_i,
    output logic    taken_o,
    output word_t   target_o
);

    bjp_info_t info;
    logic      eq;
    logic      lt;
    logic      ltu;
    logic      cond;
    word_t     jalr_sum;
    word_t     pc_sum;

    assign info = req.info.bjp;

    // Compare rs1 against rs2
    assign eq  = (req.op1 == req.op2);
    assign lt  = ($signed(req.op1) < $signed(req.op2));
    assign ltu = (req.op1 < req.op2);

    assign cond = (info.br.beq  &  eq)
                | (info.br.bne  & ~eq)
                | (info.br.blt  &  lt)
                | (info.br.bge  & ~lt)
                | (info.br.bltu &  ltu)
                | (info.br.bgeu & ~ltu);

    // Jumps always redirect
    assign taken_o = req.req & (info.jump | cond);

    assign jalr_sum = rs1_rdata_i + imm_i;
    assign pc_sum   = pc_i + imm_i;  // Branch and jal target

    // jalr clears bit 0 of the sum
    assign target_o = info.jalr ? {jalr_sum[31:1], 1'b0} : pc_sum;

endmodule

// File: rtl/exu_commit.sv
// Execute result register
// Merges unit results into one output word held under valid/ready
// back-pressure; a new item can load in the cycle the old one leaves
`timescale 1ns/1ps

module exu_commit import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    input  dec_grp_e  grp_i,
    input  logic      rd_we_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     alu_result_i,
    input  logic      taken_i,
    input  word_t     target_i,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_wdata_o,
    output logic      jump_o,
    output word_t     jump_addr_o,
    output logic      illegal_o
);

    logic illegal;
    logic load;

    assign illegal    = (grp_i == GRP_ILL);
    assign in_ready_o = ~out_valid_o | out_ready_i;  // Empty or draining now
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= 1'b1;  // Refill, even while handing one out
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // Payload only moves on an input transfer
    always_ff @(posedge clk_i) begin
        if (load) begin
            rd_we_o     <= rd_we_i & ~illegal;
            rd_addr_o   <= rd_addr_i;
            rd_wdata_o  <= alu_result_i;
            jump_o      <= taken_i & ~illegal;
            jump_addr_o <= target_i;
            illegal_o   <= illegal;
        end
    end

endmodule

// File: rtl/exu_top.sv
// Execute stage top level
// Decode, dispatch, ALU, branch unit and result register of an RV32I core
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_rdata_i,
    input  word_t     rs2_rdata_i,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_wdata_o,
    output logic      jump_o,
    output word_t     jump_addr_o,
    output logic      illegal_o
);

    dec_info_t dec_info;
    word_t     dec_imm;
    reg_addr_t dec_rd_addr;
    logic      dec_rd_we;
    word_t     alu_result;
    logic      bjp_taken;
    word_t     bjp_target;

    exu_req_if alu_req ();  // Dispatch to ALU
    exu_req_if bjp_req ();  // Dispatch to branch unit

    inst_decode u_decode (
        .inst_i     (inst_i),
        .dec_info_o (dec_info),
        .dec_imm_o  (dec_imm),
        .rd_addr_o  (dec_rd_addr),
        .rd_we_o    (dec_rd_we)
    );

    exu_dispatch u_dispatch (
        .dec_info_i  (dec_info),
        .dec_imm_i   (dec_imm),
        .dec_pc_i    (pc_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .alu_req     (alu_req.dispatch),
        .bjp_req     (bjp_req.dispatch)
    );

    exu_alu u_alu (
        .req      (alu_req.unit),
        .result_o (alu_result)
    );

    exu_bjp u_bjp (
        .req         (bjp_req.unit),
        .pc_i        (pc_i),
        .rs1_rdata_i (rs1_rdata_i),
        .imm_i       (dec_imm),
        .taken_o     (bjp_taken),
        .target_o    (bjp_target)
    );

    exu_commit u_commit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .grp_i        (dec_info.grp),
        .rd_we_i      (dec_rd_we),
        .rd_addr_i    (dec_rd_addr),
        .alu_result_i (alu_result),
        .taken_i      (bjp_taken),
        .target_i     (bjp_target),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_wdata_o   (rd_wdata_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o),
        .illegal_o    (illegal_o)
    );

endmodule

// File: dv/exu_asserts.sv
// Execute stage handshake assertions
// Bound into exu_top; reset state, hold under stall, ready rule and latency
`timescale 1ns/1ps

module exu_asserts import exu_pkg::*; (
    input logic      clk_i,
    input logic      reset_i,
    input logic      in_valid_i,
    input logic      in_ready_i,
    input logic      out_valid_i,
    input logic      out_ready_i,
    input logic      rd_we_i,
    input reg_addr_t rd_addr_i,
    input word_t     rd_wdata_i,
    input logic      jump_i,
    input word_t     jump_addr_i,
    input logic      illegal_i
);

    int unsigned reset_errs   = 0;  // Failure counts per property
    int unsigned hold_errs    = 0;
    int unsigned ready_errs   = 0;
    int unsigned latency_errs = 0;

    // Output register comes up empty
    reset_empty: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
        else begin
            $error("out_valid_o high after a reset cycle");
            reset_errs++;
        end

    // Stalled result must not move
    hold_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable({rd_we_i, rd_addr_i,
        rd_wdata_i, jump_i, jump_addr_i, illegal_i})))
        else begin
            $error("Output changed while stalled");
            hold_errs++;
        end

    ready_rule: assert property (@(posedge clk_i) disable iff (reset_i)
        in_ready_i == (!out_valid_i || out_ready_i))
        else begin
            $error("in_ready_o does not follow the output register state");
            ready_errs++;
        end

    // Single register stage
    one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        (in_valid_i && in_ready_i) |=> out_valid_i)
        else begin
            $error("No result one cycle after input transfer");
            latency_errs++;
        end

endmodule

bind exu_top exu_asserts u_asserts (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_we_i     (rd_we_o),
    .rd_addr_i   (rd_addr_o),
    .rd_wdata_i  (rd_wdata_o),
    .jump_i      (jump_o),
    .jump_addr_i (jump_addr_o),
    .illegal_i   (illegal_o)
);

// File: dv/tb_exu.sv
// Execute stage testbench
// Random RV32I stream with random output stalls, checked against an ISA model
`timescale 1ns/1ps

module tb_exu import exu_pkg::*; ();

    localparam int N_ITEMS    = 500;    // Instructions to push through
    localparam int MAX_CYCLES = 10000;  // Main loop limit

    typedef struct packed {
        logic      ill;
        logic      we;
        reg_addr_t rd;
        word_t     wdata;
        logic      jump;
        logic      addr_chk;  // jump_addr_o defined for this kind
        word_t     jaddr;
    } result_t;

    logic      clk_i;
    logic      reset_i;
    logic      in_valid_i;
    logic      in_ready_o;
    word_t     inst_i;
    word_t     pc_i;
    word_t     rs1_rdata_i;
    word_t     rs2_rdata_i;
    logic      out_valid_o;
    logic      out_ready_i;
    logic      rd_we_o;
    reg_addr_t rd_addr_o;
    word_t     rd_wdata_o;
    logic      jump_o;
    word_t     jump_addr_o;
    logic      illegal_o;

    integer    seed = 36;
    result_t   exp_q[$];  // Accepted but not yet seen at the output

    exu_top dut0 (.*);

    always #4 clk_i = ~clk_i;  // 8 ns period

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // Handshake assertion failures so far
    function automatic int unsigned assert_fail_count();
        return dut0.u_asserts.reset_errs + dut0.u_asserts.hold_errs +
               dut0.u_asserts.ready_errs + dut0.u_asserts.latency_errs;
    endfunction

    // RV32I integer op by funct3
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return word_t'(sa >>> b[4:0]);
                else
                    return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic result_t predict(input word_t inst, input word_t pc,
                                        input word_t rs1, input word_t rs2);
        result_t    r;
        logic [2:0] f3;
        word_t      imm_i;
        word_t      imm_u;
        word_t      imm_b;
        word_t      imm_j;
        f3    = inst[14:12];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_u = {inst[31:12], 12'h000};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        r     = '0;
        r.rd  = inst[11:7];
        r.ill = 1'b1;  // Anything unmatched
        case (inst[6:0])
            OPC_OP: begin
                r.ill   = 1'b0;
                r.we    = 1'b1;
                r.wdata = alu_ref(f3, inst[30], rs1, rs2);
            end
            OPC_OP_IMM: begin
                r.ill   = 1'b0;
                r.we    = 1'b1;
                r.wdata = alu_ref(f3, (f3 == 3'b101) && inst[30], rs1, imm_i);  // srai only
            end
            OPC_LUI, OPC_AUIPC: begin
                r.ill   = 1'b0;
                r.we    = 1'b1;
                r.wdata = (inst[6:0] == OPC_AUIPC) ? pc + imm_u : imm_u;
            end
            OPC_BRANCH: begin
                r.ill      = (f3[2:1] == 2'b01);  // 010 and 011 reserved
                r.addr_chk = !r.ill;
                r.jaddr    = pc + imm_b;
                case (f3)
                    3'b000: r.jump = (rs1 == rs2);
                    3'b001: r.jump = (rs1 != rs2);
                    3'b100: r.jump = ($signed(rs1) < $signed(rs2));
                    3'b101: r.jump = ($signed(rs1) >= $signed(rs2));
                    3'b110: r.jump = (rs1 < rs2);
                    3'b111: r.jump = (rs1 >= rs2);
                    default: r.jump = 1'b0;
                endcase
            end
            OPC_JAL, OPC_JALR: begin
                if (inst[6:0] == OPC_JAL || f3 == 3'b000) begin
                    r.ill      = 1'b0;
                    r.we       = 1'b1;
                    r.wdata    = pc + 32'd4;  // Link
                    r.jump     = 1'b1;
                    r.addr_chk = 1'b1;
                    r.jaddr    = (inst[6:0] == OPC_JAL) ? pc + imm_j : (rs1 + imm_i) & ~32'd1;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic gen_inst(output word_t inst);
        word_t      r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] bad_opc;
        int         kind;
        r    = $random(seed);
        kind = $unsigned($random(seed)) % 8;
        f3   = r[14:12];
        f7   = (r[31] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        case (r[2:0])
            3'd0: bad_opc = 7'b0000011;  // Load
            3'd1: bad_opc = 7'b0100011;  // Store
            3'd2: bad_opc = 7'b0001111;  // Fence
            3'd3: bad_opc = 7'b1110011;  // System
            default: bad_opc = r[6:0];   // Any opcode at all
        endcase
        case (kind)
            0: inst = {f7, r[24:7], OPC_OP};
            1: inst = (f3 == 3'b001 || f3 == 3'b101) ? {f7, r[24:7], OPC_OP_IMM} :
                                                       {r[31:7], OPC_OP_IMM};
            2: inst = {r[31:7], OPC_LUI};
            3: inst = {r[31:7], OPC_AUIPC};
            4, 5: inst = {r[31:7], OPC_BRANCH};  // Includes reserved funct3
            6: begin
                if (r[0])
                    inst = {r[31:7], OPC_JAL};
                else
                    inst = {r[31:15], r[1] ? r[14:12] : 3'b000, r[11:7], OPC_JALR};
            end
            default: inst = {r[31:7], bad_opc};
        endcase
    endtask

    task automatic drive_next();
        word_t inst;
        word_t pc;
        word_t a;
        gen_inst(inst);
        pc          = $random(seed);
        a           = $random(seed);
        inst_i      = inst;
        pc_i        = {pc[31:2], 2'b00};  // Word aligned
        rs1_rdata_i = a;
        rs2_rdata_i = ($unsigned($random(seed)) % 4 == 0) ? a : word_t'($random(seed));
        in_valid_i  = 1'b1;
    endtask

    task automatic compare_result(input result_t e);
        check_flag("illegal_o", illegal_o, e.ill);
        check_flag("rd_we_o", rd_we_o, e.we);
        check_flag("jump_o", jump_o, e.jump);
        if (e.we) begin
            check_addr("rd_addr_o", rd_addr_o, e.rd);
            check_word("rd_wdata_o", rd_wdata_o, e.wdata);
        end
        if (e.addr_chk) begin
            check_word("jump_addr_o", jump_addr_o, e.jaddr);
        end
    endtask

    initial begin
        int          sent_cnt;
        int          recv_cnt;
        int          cycle_cnt;
        int          wait_cnt;
        int unsigned assert_errs;
        logic        in_fire;
        logic        out_fire;
        logic        expect_out;
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        inst_i      = '0;
        pc_i        = '0;
        rs1_rdata_i = '0;
        rs2_rdata_i = '0;
        out_ready_i = 1'b0;
        sent_cnt    = 0;
        recv_cnt    = 0;
        cycle_cnt   = 0;
        wait_cnt    = 0;
        in_fire     = 1'b0;
        expect_out  = 1'b0;

        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        while (!in_ready_o) begin  // Should already be ready
            @(posedge clk_i);
            #1;
            wait_cnt++;
            if (wait_cnt > 16) begin
                $display("Timeout waiting for in_ready_o after reset");
                stop_on_failure();
            end
        end
        check_flag("out_valid_o", out_valid_o, 1'b0);

        while (recv_cnt < N_ITEMS) begin
            if (!in_valid_i || in_fire) begin  // Offer taken or none pending
                if (sent_cnt < N_ITEMS && ($unsigned($random(seed)) % 4 != 0))
                    drive_next();
                else
                    in_valid_i = 1'b0;
            end
            out_ready_i = ($unsigned($random(seed)) % 3 != 0);  // Stall a third of cycles

            @(negedge clk_i);  // Mid cycle where all values have settled
            in_fire  = in_valid_i && in_ready_o;
            out_fire = out_valid_o && out_ready_i;
            if (expect_out)
                check_flag("out_valid_o", out_valid_o, 1'b1);
            if (out_fire) begin
                if (exp_q.size() == 0) begin
                    $display("Output transfer at %0t with no accepted input", $time);
                    stop_on_failure();
                end
                compare_result(exp_q.pop_front());
                recv_cnt++;
            end
            if (in_fire) begin
                exp_q.push_back(predict(inst_i, pc_i, rs1_rdata_i, rs2_rdata_i));
                sent_cnt++;
            end
            expect_out = in_fire;

            @(posedge clk_i);
            #1;
            cycle_cnt++;
            if (assert_fail_count() != 0) begin
                $display("Handshake assertion failed before %0t", $time);
                stop_on_failure();
            end
            if (cycle_cnt > MAX_CYCLES) begin
                $display("Timeout waiting for results, %0d of %0d received",
                         recv_cnt, N_ITEMS);
                stop_on_failure();
            end
        end

        in_valid_i = 1'b0;
        @(posedge clk_i);  // Let the last assertions sample
        #1;
        assert_errs = assert_fail_count();
        if (assert_errs != 0) begin
            $display("Handshake assertions failed %0d times", assert_errs);
            stop_on_failure();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// File: build.f
rtl/exu_pkg.sv
rtl/exu_req_if.sv
rtl/inst_decode.sv
rtl/exu_dispatch.sv
rtl/exu_alu.sv
rtl/exu_bjp.sv
rtl/exu_commit.sv
rtl/exu_top.sv
dv/exu_asserts.sv
dv/tb_exu.sv

// File: Makefile
# Verilator flow for the execute stage

VERILATOR ?= verilator
TOP       ?= tb_exu
RTL_TOP   ?= exu_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
